// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_qla \
		-Mdir obj_dir -o tb_qla
	./obj_dir/tb_qla | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== qla_apb_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "qla_cfg.svh"

module qla_apb_slave (
    input  logic                  sysclk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`QLA_ADDR_W-1:0] paddr,
    input  qla_pkg::reg_data_t    pwdata,
    input  qla_pkg::reg_data_t    board_rdata,
    input  qla_pkg::reg_data_t    enc_rdata,
    output qla_pkg::reg_data_t    prdata,
    output logic                  pready,
    output logic                  pslverr,
    output qla_pkg::reg_wr_t      reg_wr,
    output qla_pkg::reg_rd_t      reg_rd
);

    localparam int HI_LSB = `QLA_CHAN_LSB + `QLA_CHAN_W;  // first unused addr bit

    logic               access;     // second apb phase
    logic               addr_ok;    // chan 0..4, upper bits clear
    logic               wen_q;
    qla_pkg::chan_t     chan_q;
    qla_pkg::off_t      off_q;
    qla_pkg::reg_data_t data_q;
    qla_pkg::reg_data_t rd_sel;

    assign reg_rd.chan = paddr[`QLA_CHAN_LSB +: `QLA_CHAN_W];
    assign reg_rd.off  = paddr[`QLA_CHAN_LSB-1:0];

    assign access  = psel && penable;
    assign addr_ok = (paddr[`QLA_ADDR_W-1:HI_LSB] == '0) &&
                     (reg_rd.chan <= qla_pkg::chan_t'(`QLA_NUM_AXES));

    assign pready  = 1'b1;                 // no wait states
    assign pslverr = access && !addr_ok;

    // ------------------------------
    // write strobe
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wen_q <= 1'b0;
        end else begin
            wen_q <= access && pwrite && addr_ok;  // one-cycle pulse
        end
    end

    always_ff @(posedge sysclk) begin
        chan_q <= reg_rd.chan;   // payload follows the address every cycle
        off_q  <= reg_rd.off;
        data_q <= pwdata;
    end

    assign reg_wr = '{wen: wen_q, chan: chan_q, off: off_q, data: data_q};

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb begin
        rd_sel = '0;
        if (reg_rd.chan == '0) begin
            rd_sel = board_rdata;                          // board i/o channel
        end else if (reg_rd.off == `QLA_OFF_DAC_CMD) begin
            rd_sel = board_rdata;
        end else if (reg_rd.off == `QLA_OFF_ENC_LOAD ||
                     reg_rd.off == `QLA_OFF_ENC_DATA) begin
            rd_sel = enc_rdata;
        end
    end

    assign prdata = (access && addr_ok) ? rd_sel : '0;   // bad address reads zero

endmodule

`default_nettype wire

// ==== qla_board_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "qla_cfg.svh"

module qla_board_regs (
    input  logic               sysclk,
    input  logic               rst_n,
    input  qla_pkg::reg_wr_t   reg_wr,
    input  qla_pkg::reg_rd_t   reg_rd,
    input  qla_pkg::chan_t     board_id,
    input  qla_pkg::axis_vec_t safety_disable,
    output qla_pkg::reg_data_t board_rdata,
    output qla_pkg::cur_word_t cur_cmd [`QLA_NUM_AXES],
    output qla_pkg::axis_vec_t amp_enable_out,
    output qla_pkg::axis_vec_t dout_pins,
    output logic               amp_en_wr
);

    localparam int AXIS_W = $clog2(`QLA_NUM_AXES);

    qla_pkg::axis_vec_t amp_mask;     // host enable request
    qla_pkg::axis_vec_t dout_val;
    logic               dout_bidir;   // invert outputs in bidir mode
    logic               chan0_wr;
    logic               dac_wr;
    logic [AXIS_W-1:0]  wr_axis;
    logic [AXIS_W-1:0]  rd_axis;
    qla_pkg::reg_data_t status;

    assign wr_axis = AXIS_W'(reg_wr.chan - 1'b1);
    assign rd_axis = AXIS_W'(reg_rd.chan - 1'b1);

    assign chan0_wr  = reg_wr.wen && (reg_wr.chan == '0);
    assign dac_wr    = reg_wr.wen && (reg_wr.chan != '0) && (reg_wr.off == `QLA_OFF_DAC_CMD);
    assign amp_en_wr = chan0_wr && (reg_wr.off == `QLA_OFF_AMP_EN);  // also clears faults

    // ------------------------------
    // channel 0 registers
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            amp_mask   <= '0;
            dout_val   <= '0;
            dout_bidir <= 1'b0;
        end else begin
            if (amp_en_wr) begin
                amp_mask <= reg_wr.data[`QLA_NUM_AXES-1:0];
            end
            if (chan0_wr && reg_wr.off == `QLA_OFF_DOUT) begin
                dout_val   <= reg_wr.data[`QLA_NUM_AXES-1:0];
                dout_bidir <= reg_wr.data[`QLA_DOUT_BIDIR_BIT];
            end
        end
    end

    // dac command words, midscale is zero current
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                cur_cmd[i] <= `QLA_CUR_MID;
            end
        end else if (dac_wr) begin
            cur_cmd[wr_axis] <= reg_wr.data[`QLA_CUR_W-1:0];
        end
    end

    assign amp_enable_out = amp_mask & ~safety_disable;       // tripped axes forced off
    assign dout_pins      = dout_bidir ? ~dout_val : dout_val;

    // id, signature and live state
    assign status = {`QLA_STATUS_SIG, 3'b000, dout_bidir, board_id,
                     safety_disable, amp_enable_out};

    // ------------------------------
    // readback
    // ------------------------------
    always_comb begin
        board_rdata = '0;
        if (reg_rd.chan == '0) begin
            case (reg_rd.off)
                `QLA_OFF_STATUS: board_rdata = status;
                `QLA_OFF_AMP_EN: board_rdata = qla_pkg::reg_data_t'(amp_mask);
                `QLA_OFF_DOUT:   board_rdata = qla_pkg::reg_data_t'({dout_bidir, dout_val});
                default:         board_rdata = '0;
            endcase
        end else if (reg_rd.off == `QLA_OFF_DAC_CMD) begin
            board_rdata = qla_pkg::reg_data_t'(cur_cmd[rd_axis]);
        end
    end

endmodule

`default_nettype wire

// ==== qla_cfg.svh ====
`ifndef QLA_CFG_SVH
`define QLA_CFG_SVH

// ------------------------------
// sizes
// ------------------------------
`define QLA_NUM_AXES        4
`define QLA_ADDR_W          16        // apb address width
`define QLA_DATA_W          32
`define QLA_CUR_W           16        // adc / dac word
`define QLA_ENC_W           24        // quadrature count
`define QLA_CHAN_W          4
`define QLA_OFF_W           4

// ------------------------------
// address map
// ------------------------------
`define QLA_CHAN_LSB        4         // addr[7:4] channel, addr[3:0] offset
`define QLA_OFF_STATUS      4'd0      // channel 0
`define QLA_OFF_AMP_EN      4'd1      // channel 0
`define QLA_OFF_DOUT        4'd2      // channel 0
`define QLA_OFF_DAC_CMD     4'd1      // axis channels 1..4
`define QLA_OFF_ENC_LOAD    4'd2      // axis channels 1..4
`define QLA_OFF_ENC_DATA    4'd3      // axis channels 1..4
`define QLA_DOUT_BIDIR_BIT  4         // bidir flag in the dout word
`define QLA_STATUS_SIG      16'h0A51  // upper half of status

// ------------------------------
// safety check
// ------------------------------
`define QLA_CUR_MID         16'h8000  // zero current, offset binary
`define QLA_SAFETY_MARGIN   16'h0100
`define QLA_SAFETY_COUNT    8         // consecutive cycles before latch

`endif

// ==== qla_enc_quad.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "qla_cfg.svh"

module qla_enc_quad (
    input  logic               sysclk,
    input  logic               rst_n,
    input  qla_pkg::axis_vec_t enc_a,
    input  qla_pkg::axis_vec_t enc_b,
    input  qla_pkg::reg_wr_t   reg_wr,
    input  qla_pkg::reg_rd_t   reg_rd,
    output qla_pkg::reg_data_t enc_rdata
);

    localparam int AXIS_W = $clog2(`QLA_NUM_AXES);
    localparam int EXT_W  = `QLA_DATA_W - `QLA_ENC_W;   // sign extension bits

    qla_pkg::axis_vec_t  a_s1, a_s2, a_q;   // two sync flops + previous state
    qla_pkg::axis_vec_t  b_s1, b_s2, b_q;
    qla_pkg::axis_vec_t  step;               // exactly one line changed
    qla_pkg::axis_vec_t  dir_up;
    qla_pkg::axis_vec_t  load;
    qla_pkg::enc_count_t count   [`QLA_NUM_AXES];
    qla_pkg::enc_count_t preload [`QLA_NUM_AXES];
    logic [AXIS_W-1:0]   wr_axis;
    logic [AXIS_W-1:0]   rd_axis;

    assign wr_axis = AXIS_W'(reg_wr.chan - 1'b1);   // chan 1..4 -> axis 0..3
    assign rd_axis = AXIS_W'(reg_rd.chan - 1'b1);

    // ------------------------------
    // synchronizers
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            a_s1 <= '0;
            a_s2 <= '0;
            a_q  <= '0;
            b_s1 <= '0;
            b_s2 <= '0;
            b_q  <= '0;
        end else begin
            a_s1 <= enc_a;
            a_s2 <= a_s1;
            a_q  <= a_s2;      // last seen state for the edge compare
            b_s1 <= enc_b;
            b_s2 <= b_s1;
            b_q  <= b_s2;
        end
    end

    // x4 decode, forward is 00 -> 10 -> 11 -> 01 (a leads b)
    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_dec
        assign step[i]   = (a_s2[i] ^ a_q[i]) ^ (b_s2[i] ^ b_q[i]);  // double step gives 0
        assign dir_up[i] = a_s2[i] ^ b_q[i];
        assign load[i]   = reg_wr.wen && (reg_wr.chan != '0) &&
                           (reg_wr.off == `QLA_OFF_ENC_LOAD) &&
                           (wr_axis == AXIS_W'(i));
    end

    // ------------------------------
    // counters
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                count[i]   <= '0;
                preload[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (load[i]) begin                     // preload wins over a step
                    count[i]   <= reg_wr.data[`QLA_ENC_W-1:0];
                    preload[i] <= reg_wr.data[`QLA_ENC_W-1:0];
                end else if (step[i]) begin
                    count[i] <= dir_up[i] ? count[i] + 1'b1 : count[i] - 1'b1;
                end
            end
        end
    end

    // readback, both words sign-extended
    always_comb begin
        enc_rdata = '0;
        if (reg_rd.chan != '0) begin
            case (reg_rd.off)
                `QLA_OFF_ENC_DATA: enc_rdata = {{EXT_W{count[rd_axis][`QLA_ENC_W-1]}},
                                                count[rd_axis]};
                `QLA_OFF_ENC_LOAD: enc_rdata = {{EXT_W{preload[rd_axis][`QLA_ENC_W-1]}},
                                                preload[rd_axis]};
                default:           enc_rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== qla_pkg.sv ====
`default_nettype none

`include "qla_cfg.svh"

package qla_pkg;

    // widths with a meaning of their own
    typedef logic        [`QLA_CUR_W-1:0]    cur_word_t;   // offset binary current
    typedef logic signed [`QLA_ENC_W-1:0]    enc_count_t;  // encoder position
    typedef logic        [`QLA_CHAN_W-1:0]   chan_t;
    typedef logic        [`QLA_OFF_W-1:0]    off_t;
    typedef logic        [`QLA_DATA_W-1:0]   reg_data_t;
    typedef logic        [`QLA_NUM_AXES-1:0] axis_vec_t;   // bit i = axis i+1

    // ------------------------------
    // register bus
    // ------------------------------

    // write strobe, one cycle after the apb access
    typedef struct packed {
        logic      wen;
        chan_t     chan;
        off_t      off;
        reg_data_t data;
    } reg_wr_t;

    // read address, straight from paddr
    typedef struct packed {
        chan_t chan;
        off_t  off;
    } reg_rd_t;

endpackage

`default_nettype wire

// ==== qla_safety_check.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "qla_cfg.svh"

module qla_safety_check (
    input  logic               sysclk,
    input  logic               rst_n,
    input  qla_pkg::cur_word_t cur_fb  [`QLA_NUM_AXES],
    input  qla_pkg::cur_word_t cur_cmd [`QLA_NUM_AXES],
    input  logic               amp_en_wr,       // clear all latches
    output qla_pkg::axis_vec_t safety_disable
);

    localparam int CNT_W = $clog2(`QLA_SAFETY_COUNT + 1);
    localparam int LIM_W = `QLA_CUR_W + 2;      // room for 2*cmd + margin

    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_axis
        qla_pkg::cur_word_t fb_mag;             // distance from midscale
        qla_pkg::cur_word_t cmd_mag;
        logic [LIM_W-1:0]   limit;
        logic               over;
        logic [CNT_W-1:0]   cnt;                // consecutive over-current cycles
        logic               tripped;

        assign fb_mag  = (cur_fb[i] >= `QLA_CUR_MID) ? cur_fb[i] - `QLA_CUR_MID
                                                     : `QLA_CUR_MID - cur_fb[i];
        assign cmd_mag = (cur_cmd[i] >= `QLA_CUR_MID) ? cur_cmd[i] - `QLA_CUR_MID
                                                      : `QLA_CUR_MID - cur_cmd[i];
        assign limit   = {1'b0, cmd_mag, 1'b0} + LIM_W'(`QLA_SAFETY_MARGIN);
        assign over    = LIM_W'(fb_mag) > limit;

        always_ff @(posedge sysclk or negedge rst_n) begin
            if (!rst_n) begin
                cnt     <= '0;
                tripped <= 1'b0;
            end else if (amp_en_wr) begin
                cnt     <= '0;
                tripped <= 1'b0;
            end else begin
                if (!over) begin
                    cnt <= '0;                                  // any gap restarts
                end else if (cnt != CNT_W'(`QLA_SAFETY_COUNT)) begin
                    cnt <= cnt + 1'b1;                          // saturate at the limit
                end
                if (cnt == CNT_W'(`QLA_SAFETY_COUNT)) begin
                    tripped <= 1'b1;                            // held until amp write
                end
            end
        end

        assign safety_disable[i] = tripped;
    end

endmodule

`default_nettype wire

// ==== qla_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "qla_cfg.svh"

module qla_top (
    input  logic                  sysclk,
    input  logic                  rst_n,
    // apb slave port
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`QLA_ADDR_W-1:0] paddr,
    input  qla_pkg::reg_data_t    pwdata,
    output qla_pkg::reg_data_t    prdata,
    output logic                  pready,
    output logic                  pslverr,
    // axis i/o
    input  qla_pkg::axis_vec_t    enc_a,
    input  qla_pkg::axis_vec_t    enc_b,
    input  qla_pkg::cur_word_t    cur_fb [`QLA_NUM_AXES],   // adc words
    input  qla_pkg::chan_t        board_id,                 // rotary switch
    output qla_pkg::cur_word_t    cur_cmd [`QLA_NUM_AXES],  // dac words
    output qla_pkg::axis_vec_t    amp_enable_out,
    output qla_pkg::axis_vec_t    dout_pins
);

    // ------------------------------
    // local wires
    // ------------------------------
    qla_pkg::reg_wr_t   reg_wr;          // registered write strobe
    qla_pkg::reg_rd_t   reg_rd;          // read address
    qla_pkg::reg_data_t board_rdata;     // chan 0 + dac reads
    qla_pkg::reg_data_t enc_rdata;       // encoder reads
    qla_pkg::axis_vec_t safety_disable;  // latched over-current
    logic               amp_en_wr;       // clears the safety latches

    qla_apb_slave apb0 (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .board_rdata (board_rdata),
        .enc_rdata   (enc_rdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd)
    );

    qla_enc_quad enc0 (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .enc_rdata (enc_rdata)
    );

    qla_board_regs chan0 (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .board_id       (board_id),
        .safety_disable (safety_disable),
        .board_rdata    (board_rdata),
        .cur_cmd        (cur_cmd),
        .amp_enable_out (amp_enable_out),
        .dout_pins      (dout_pins),
        .amp_en_wr      (amp_en_wr)
    );

    qla_safety_check safe0 (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .cur_fb         (cur_fb),
        .cur_cmd        (cur_cmd),
        .amp_en_wr      (amp_en_wr),
        .safety_disable (safety_disable)
    );

endmodule

`default_nettype wire

// ==== tb_qla.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "qla_cfg.svh"

module tb_qla;

    localparam int N = `QLA_NUM_AXES;
    localparam int WATCHDOG_CYCLES = 2 * (64 + 256 + 1024 + 128 + 64);  // test lengths x2

    logic                   sysclk = 1'b0;
    logic                   rst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`QLA_ADDR_W-1:0] paddr;
    qla_pkg::reg_data_t     pwdata;
    qla_pkg::reg_data_t     prdata;
    logic                   pready;
    logic                   pslverr;
    qla_pkg::axis_vec_t     enc_a;
    qla_pkg::axis_vec_t     enc_b;
    qla_pkg::cur_word_t     cur_fb  [N];
    qla_pkg::cur_word_t     cur_cmd [N];
    qla_pkg::chan_t         board_id;
    qla_pkg::axis_vec_t     amp_enable_out;
    qla_pkg::axis_vec_t     dout_pins;

    // expected state, kept from the register rules
    qla_pkg::axis_vec_t     exp_mask;
    qla_pkg::axis_vec_t     exp_dis;
    qla_pkg::axis_vec_t     exp_dout_val;
    logic                   exp_bidir;
    qla_pkg::cur_word_t     exp_cmd [N];
    qla_pkg::axis_vec_t     exp_amp;
    qla_pkg::axis_vec_t     exp_pins;
    logic                   out_chk;
    logic                   bus_chk;
    logic                   bus_rd;
    logic                   exp_err;
    qla_pkg::reg_data_t     exp_rdata;
    int                     chk_errs;
    int                     chk_count;

    integer                 seed = 52744;
    int                     phase [N];       // gray position per axis
    int                     test_num;
    int                     err_base;
    int                     failed_tests;

    always #20 sysclk = ~sysclk;             // 40 ns

    qla_top dut0 (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .enc_a          (enc_a),
        .enc_b          (enc_b),
        .cur_fb         (cur_fb),
        .board_id       (board_id),
        .cur_cmd        (cur_cmd),
        .amp_enable_out (amp_enable_out),
        .dout_pins      (dout_pins)
    );

    tb_qla_checker chk0 (
        .sysclk         (sysclk),
        .out_chk        (out_chk),
        .exp_amp        (exp_amp),
        .amp_enable_out (amp_enable_out),
        .exp_pins       (exp_pins),
        .dout_pins      (dout_pins),
        .exp_cmd        (exp_cmd),
        .cur_cmd        (cur_cmd),
        .bus_chk        (bus_chk),
        .bus_rd         (bus_rd),
        .pready         (pready),
        .exp_err        (exp_err),
        .pslverr        (pslverr),
        .exp_rdata      (exp_rdata),
        .prdata         (prdata),
        .err_cnt        (chk_errs),
        .chk_cnt        (chk_count)
    );

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic qla_pkg::axis_vec_t dout_ref(input qla_pkg::axis_vec_t val,
                                                    input logic bidir);
        return bidir ? ~val : val;
    endfunction

    function automatic qla_pkg::reg_data_t status_ref(input qla_pkg::axis_vec_t amp_out,
                                                      input qla_pkg::axis_vec_t dis,
                                                      input qla_pkg::chan_t id,
                                                      input logic bidir);
        return {16'h0A51, 3'b000, bidir, id, dis, amp_out};
    endfunction

    function automatic qla_pkg::reg_data_t enc_ref(input logic [`QLA_ENC_W-1:0] pre,
                                                   input int fwd, input int rev);
        logic [`QLA_ENC_W-1:0] c;
        c = pre + `QLA_ENC_W'(fwd) - `QLA_ENC_W'(rev);   // wraps like the counter
        return {{(`QLA_DATA_W - `QLA_ENC_W){c[`QLA_ENC_W-1]}}, c};
    endfunction

    // over-current when |fb| > 2|cmd| + margin, both about midscale
    function automatic logic trip_ref(input qla_pkg::cur_word_t fb,
                                      input qla_pkg::cur_word_t cmd);
        int fb_mag;
        int cmd_mag;
        fb_mag  = int'(fb) - int'(`QLA_CUR_MID);
        cmd_mag = int'(cmd) - int'(`QLA_CUR_MID);
        if (fb_mag < 0) fb_mag = -fb_mag;
        if (cmd_mag < 0) cmd_mag = -cmd_mag;
        return fb_mag > 2 * cmd_mag + int'(`QLA_SAFETY_MARGIN);
    endfunction

    function automatic logic [1:0] gray_ab(input int p);   // {a, b}, a leads b
        case (p)
            0:       return 2'b00;
            1:       return 2'b10;
            2:       return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    function automatic logic [`QLA_ADDR_W-1:0] addr_of(input qla_pkg::chan_t ch,
                                                       input qla_pkg::off_t off);
        return {8'h00, ch, off};
    endfunction

    function automatic logic addr_invalid(input logic [`QLA_ADDR_W-1:0] addr);
        return (addr[15:8] != 8'h00) || (addr[7:4] > 4'(N));
    endfunction

    assign exp_amp  = exp_mask & ~exp_dis;
    assign exp_pins = dout_ref(exp_dout_val, exp_bidir);

    // ------------------------------
    // bus and timing helpers
    // ------------------------------
    task automatic next_cycle(input int n);
        repeat (n) begin
            @(posedge sysclk);
            #2;
        end
    endtask

    task automatic check_outputs();
        out_chk = 1'b1;               // one sample at the next negedge
        next_cycle(1);
        out_chk = 1'b0;
    endtask

    task automatic apb_xfer(input logic wr, input logic [`QLA_ADDR_W-1:0] addr,
                            input qla_pkg::reg_data_t wdata, input qla_pkg::reg_data_t exp_rd,
                            input logic exp_e);
        @(posedge sysclk);
        #2;
        psel    = 1'b1;               // setup
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge sysclk);
        #2;
        penable   = 1'b1;             // access
        bus_chk   = 1'b1;
        bus_rd    = !wr;
        exp_rdata = exp_rd;
        exp_err   = exp_e;
        @(posedge sysclk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        bus_chk = 1'b0;
        bus_rd  = 1'b0;
    endtask

    task automatic apb_write(input logic [`QLA_ADDR_W-1:0] addr, input qla_pkg::reg_data_t data);
        apb_xfer(1'b1, addr, data, 32'd0, addr_invalid(addr));
    endtask

    task automatic apb_read(input logic [`QLA_ADDR_W-1:0] addr, input qla_pkg::reg_data_t exp);
        apb_xfer(1'b0, addr, 32'd0, addr_invalid(addr) ? 32'd0 : exp, addr_invalid(addr));
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = chk_errs - err_base;
        $display("test %0d %s: %s, %0d mismatches", test_num, name,
                 (errs == 0) ? "ok" : "failed", errs);
        if (errs != 0) failed_tests++;
        err_base = chk_errs;
        test_num++;
    endtask

    task automatic read_status();
        apb_read(addr_of(4'd0, `QLA_OFF_STATUS),
                 status_ref(exp_mask & ~exp_dis, exp_dis, board_id, exp_bidir));
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic test_regs();
        qla_pkg::reg_data_t word;
        qla_pkg::axis_vec_t v;
        for (int ax = 0; ax < N; ax++) begin
            word = $random(seed);                        // upper half ignored
            apb_write(addr_of(qla_pkg::chan_t'(ax + 1), `QLA_OFF_DAC_CMD), word);
            exp_cmd[ax] = word[15:0];
            next_cycle(1);
            check_outputs();
            apb_read(addr_of(qla_pkg::chan_t'(ax + 1), `QLA_OFF_DAC_CMD), {16'h0, word[15:0]});
        end
        for (int b = 0; b < 2; b++) begin
            v = qla_pkg::axis_vec_t'($random(seed));
            apb_write(addr_of(4'd0, `QLA_OFF_DOUT), {27'd0, 1'(b), v});
            exp_dout_val = v;
            exp_bidir    = 1'(b);
            next_cycle(1);
            check_outputs();
            apb_read(addr_of(4'd0, `QLA_OFF_DOUT), {27'd0, 1'(b), v});
        end
        v = qla_pkg::axis_vec_t'($random(seed)) | 4'b0001;  // never an empty mask
        apb_write(addr_of(4'd0, `QLA_OFF_AMP_EN), {28'd0, v});
        exp_mask = v;
        next_cycle(1);
        check_outputs();
        apb_read(addr_of(4'd0, `QLA_OFF_AMP_EN), {28'd0, v});
        read_status();
    endtask

    task automatic test_encoder();
        qla_pkg::reg_data_t    word;
        logic [`QLA_ENC_W-1:0] pre;
        int                    nsteps;
        int                    fwd;
        int                    rev;
        for (int ax = 0; ax < N; ax++) begin
            word   = $random(seed);
            pre    = word[`QLA_ENC_W-1:0];
            fwd    = 0;
            rev    = 0;
            nsteps = 1 + ({$random(seed)} % 24);
            apb_write(addr_of(qla_pkg::chan_t'(ax + 1), `QLA_OFF_ENC_LOAD), word);
            next_cycle(1);
            for (int s = 0; s < nsteps; s++) begin
                if ({$random(seed)} % 2 == 0) begin
                    phase[ax] = (phase[ax] + 1) % 4;     // forward
                    fwd++;
                end else begin
                    phase[ax] = (phase[ax] + 3) % 4;     // reverse
                    rev++;
                end
                {enc_a[ax], enc_b[ax]} = gray_ab(phase[ax]);
                next_cycle(4);                           // sync + compare is 3
            end
            apb_read(addr_of(qla_pkg::chan_t'(ax + 1), `QLA_OFF_ENC_DATA), enc_ref(pre, fwd, rev));
            apb_read(addr_of(qla_pkg::chan_t'(ax + 1), `QLA_OFF_ENC_LOAD), enc_ref(pre, 0, 0));
        end
    endtask

    task automatic test_overcurrent();
        qla_pkg::cur_word_t m;
        qla_pkg::cur_word_t cmd;
        qla_pkg::cur_word_t fb;
        m   = qla_pkg::cur_word_t'($random(seed)) & 16'h0FFF;
        cmd = `QLA_CUR_MID + m;
        fb  = cmd + m + `QLA_SAFETY_MARGIN + 16'd1 + (qla_pkg::cur_word_t'($random(seed)) & 16'h00FF);
        apb_write(addr_of(4'd0, `QLA_OFF_AMP_EN), 32'h0000_000F);
        exp_mask = 4'hF;
        apb_write(addr_of(4'd2, `QLA_OFF_DAC_CMD), {16'h0, cmd});   // axis 2
        exp_cmd[1] = cmd;
        next_cycle(1);
        check_outputs();
        cur_fb[1] = fb;
        next_cycle(`QLA_SAFETY_COUNT);
        check_outputs();                          // still counting
        exp_dis[1] = trip_ref(fb, cmd);
        check_outputs();                          // latched one cycle later
        read_status();
        cur_fb[1] = `QLA_CUR_MID;                 // fault must stay latched
        next_cycle(4);
        check_outputs();
        read_status();
        apb_write(addr_of(4'd0, `QLA_OFF_AMP_EN), 32'h0000_000F);
        exp_dis = '0;
        next_cycle(1);
        check_outputs();
        read_status();
    endtask

    task automatic test_errors();
        apb_write(16'h0061, $random(seed));      // channel 6
        apb_read(16'h0063, 32'd0);
        apb_write(16'h0101, 32'h0000_0000);      // aliases amp enable
        apb_write(16'h0211, 32'h0000_1234);      // aliases axis 1 dac
        apb_read(16'h0100, 32'd0);
        next_cycle(1);
        check_outputs();
        apb_read(addr_of(4'd0, `QLA_OFF_AMP_EN), {28'd0, exp_mask});
        apb_read(addr_of(4'd1, `QLA_OFF_DAC_CMD), {16'h0, exp_cmd[0]});
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        enc_a    = '0;
        enc_b    = '0;
        board_id = qla_pkg::chan_t'($random(seed));
        for (int i = 0; i < N; i++) begin
            cur_fb[i]  = `QLA_CUR_MID;            // zero current
            exp_cmd[i] = `QLA_CUR_MID;
            phase[i]   = 0;
        end
        exp_mask     = '0;
        exp_dis      = '0;
        exp_dout_val = '0;
        exp_bidir    = 1'b0;
        out_chk      = 1'b0;
        bus_chk      = 1'b0;
        bus_rd       = 1'b0;
        exp_err      = 1'b0;
        exp_rdata    = '0;
        test_num     = 1;
        err_base     = 0;
        failed_tests = 0;
        repeat (8) @(posedge sysclk);
        #2;
        rst_n = 1'b1;

        check_outputs();
        read_status();
        finish_test("reset and status");
        test_regs();
        finish_test("register writes");
        test_encoder();
        finish_test("encoder counting");
        test_overcurrent();
        finish_test("over-current latch");
        test_errors();
        finish_test("error response");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                 test_num - 1, failed_tests, chk_count, chk_errs);
        if (failed_tests == 0 && chk_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sysclk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_qla_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "qla_cfg.svh"

module tb_qla_checker (
    input  logic               sysclk,
    // output checks
    input  logic               out_chk,
    input  qla_pkg::axis_vec_t exp_amp,
    input  qla_pkg::axis_vec_t amp_enable_out,
    input  qla_pkg::axis_vec_t exp_pins,
    input  qla_pkg::axis_vec_t dout_pins,
    input  qla_pkg::cur_word_t exp_cmd [`QLA_NUM_AXES],
    input  qla_pkg::cur_word_t cur_cmd [`QLA_NUM_AXES],
    // bus checks, access cycle only
    input  logic               bus_chk,
    input  logic               bus_rd,       // also compare prdata
    input  logic               pready,
    input  logic               exp_err,
    input  logic               pslverr,
    input  qla_pkg::reg_data_t exp_rdata,
    input  qla_pkg::reg_data_t prdata,
    output int                 err_cnt,
    output int                 chk_cnt
);

    int errs = 0;
    int checks = 0;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // ------------------------------
    // sample mid cycle, inputs move just after posedge
    // ------------------------------
    always @(negedge sysclk) begin
        if (out_chk) begin
            compare("amp_enable_out", 32'(amp_enable_out), 32'(exp_amp));
            compare("dout_pins", 32'(dout_pins), 32'(exp_pins));
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                compare($sformatf("cur_cmd[%0d]", i), 32'(cur_cmd[i]), 32'(exp_cmd[i]));
            end
        end
        if (bus_chk) begin
            compare("pready", 32'(pready), 32'(1'b1));   // no wait states
            compare("pslverr", 32'(pslverr), 32'(exp_err));
            if (bus_rd) begin
                compare("prdata", prdata, exp_rdata);   // combinational read data
            end
        end
    end

    assign err_cnt = errs;
    assign chk_cnt = checks;

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
qla_pkg.sv
qla_apb_slave.sv
qla_enc_quad.sv
qla_board_regs.sv
qla_safety_check.sv
qla_top.sv
tb_qla_checker.sv
tb_qla.sv
